/* fir_interp_trace.txt */
// Each vector spans two lines: in_l in_r, then out_l out_r for phases 0..7 (18-bit hex)
// First line holds the inputs and phases 0 to 2, second line phases 3 to 7
10000 00000 3FFF4 00000 3FFF0 00000 3FFFE 00000
00031 00000 00098 00000 00138 00000 00201 00000 002C3 00000
00000 00000 0032F 00000 002DC 00000 0015F 00000
3FE65 00000 3F9DC 00000 3F417 00000 3EDE7 00000 3E89D 00000
00000 20000 3E5F2 00018 3E7CE 00020 3EFF9 00004
3FFB9 3FF9E 01781 3FED0 036A8 3FD90 05B56 3FBFE 082A2 3FA7A
20000 20000 0A8F7 3F9BA 0CA37 3FA68 0E2A5 3FD46
0EF48 002D4 0EE7A 00B18 0E031 01562 0C615 02030 0A359 02940
00000 00000 07C44 02DBE 0559E 02AAC 033EA 01D50
01AB7 003C4 00C01 3DD46 007CB 3AA82 00C00 36D86 014B8 32982
3FFFF 00000 01CB9 2E25E 01E4B 29C36 01425 25ACC
3FA69 2213A 3CF62 1F1AA 3940E 1CD6E 34C2F 1B526 2FDEA 1A8FE

/* fir_interp.f */
fir_interp_pkg.sv
fir_interp_seq.sv
fir_interp_index_timer.sv
fir_interp_delay_line.sv
fir_interp_coef_rom.sv
fir_interp_mac_lane.sv
fir_interp_8x.sv
fir_interp_chk.sv
fir_interp_tb.sv

/* fir_interp_tb.sv */
/*
 * Testbench for the stereo 8x interpolating FIR
 * Reads input pairs and expected output bursts from the
 * trace file, drives on the falling edge and checks the
 * values, the strobe spacing and the done pulse.
 */
`timescale 1ns/1ns

module fir_interp_tb;

    localparam int num_vectors      = 6;
    localparam int words_per_vector = 2 + 2 * fir_interp_pkg::num_phases;
    localparam int wait_limit       = 200;
    localparam int min_spacing      = 84;
    localparam int first_latency    = 12;
    localparam int phase_spacing    = 10;
    localparam int idle_cycles      = 100;

    logic                                reset;
    logic                                clk;
    logic                                sample_in_rdy;
    logic [fir_interp_pkg::sample_w-1:0] sample_in_l;
    logic [fir_interp_pkg::sample_w-1:0] sample_in_r;
    logic                                sample_out_rdy;
    logic [fir_interp_pkg::sample_w-1:0] sample_out_l;
    logic [fir_interp_pkg::sample_w-1:0] sample_out_r;
    logic                                done;

    logic [fir_interp_pkg::sample_w-1:0] trace_mem [num_vectors * words_per_vector];

    fir_interp_8x uut (
        .reset(reset),
        .clk(clk),
        .sample_in_rdy(sample_in_rdy),
        .sample_in_l(sample_in_l),
        .sample_in_r(sample_in_r),
        .sample_out_rdy(sample_out_rdy),
        .sample_out_l(sample_out_l),
        .sample_out_r(sample_out_r),
        .done(done)
    );

    bind fir_interp_8x fir_interp_chk u_chk (
        .reset(reset),
        .clk(clk),
        .sample_out_rdy(sample_out_rdy),
        .done(done),
        .sample_out_l(sample_out_l),
        .sample_out_r(sample_out_r)
    );

    initial begin
        reset = 1'b0;
        forever #5 reset = ~reset;
    end

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("TEST FAIL");
            $fatal(1, "value check failed");
        end
    endtask

    // Counts falling edges until the output strobe shows up
    task automatic wait_for_output(output int cycles);
        int count;
        count = 0;
        do begin
            @(negedge reset);
            count++;
            if (!sample_out_rdy) begin
                check_value("done between strobes", done, 0);
            end
        end while (!sample_out_rdy && count < wait_limit);
        if (!sample_out_rdy) begin
            $display("Timeout at %0t ns: no output strobe within %0d cycles", $time, wait_limit);
            $display("TEST FAIL");
            $fatal(1, "output strobe timeout");
        end
        cycles = count;
    endtask

    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(negedge reset);
            check_value("sample_out_rdy while idle", sample_out_rdy, 0);
            check_value("done while idle", done, 0);
            check_value("sample_out_l while idle", sample_out_l, 0);
            check_value("sample_out_r while idle", sample_out_r, 0);
        end
    endtask

    // One input pair and its burst of eight outputs
    task automatic run_vector(input int v);
        int base;
        int cycles;
        int gap;
        base = v * words_per_vector;
        sample_in_rdy = 1'b1;
        sample_in_l   = trace_mem[base];
        sample_in_r   = trace_mem[base + 1];
        @(negedge reset);
        sample_in_rdy = 1'b0;
        sample_in_l   = '0;
        sample_in_r   = '0;
        for (int p = 0; p < fir_interp_pkg::num_phases; p++) begin
            wait_for_output(cycles);
            check_value($sformatf("vector %0d phase %0d strobe spacing", v, p), cycles,
                        (p == 0) ? first_latency - 1 : phase_spacing);
            check_value($sformatf("vector %0d phase %0d left", v, p), sample_out_l,
                        trace_mem[base + 2 + 2 * p]);
            check_value($sformatf("vector %0d phase %0d right", v, p), sample_out_r,
                        trace_mem[base + 3 + 2 * p]);
            check_value($sformatf("vector %0d phase %0d done", v, p), done,
                        (p == fir_interp_pkg::num_phases - 1) ? 1 : 0);
        end
        // Burst ends 82 cycles after the input strobe
        gap = $urandom % 41;
        repeat (min_spacing - 82 + gap) @(negedge reset);
    endtask

    initial begin
        void'($urandom(89));
        clk           = 1'b1;
        sample_in_rdy = 1'b0;
        sample_in_l   = '0;
        sample_in_r   = '0;

        $readmemh("fir_interp_trace.txt", trace_mem);
        if ($isunknown(trace_mem[num_vectors * words_per_vector - 1])) begin
            $display("Trace file could not be read or is too short");
            $display("TEST FAIL");
            $fatal(1, "missing trace data");
        end

        repeat (5) @(posedge reset);
        @(negedge reset);
        clk = 1'b0;

        // ----------------------------------------
        // Quiet after reset, then the trace
        // ----------------------------------------
        check_idle(idle_cycles);
        for (int v = 0; v < num_vectors; v++) begin
            run_vector(v);
        end
        check_idle(idle_cycles);

        $display("TEST PASS");
        $finish;
    end

endmodule

/* fir_interp_chk.sv */
/*
 * FIR output protocol checker
 * Bound to the top level. Checks the output strobe,
 * the done pulse and the idle data outputs.
 */
`timescale 1ns/1ns

module fir_interp_chk (
    input logic                                reset,
    input logic                                clk,
    input logic                                sample_out_rdy,
    input logic                                done,
    input logic [fir_interp_pkg::sample_w-1:0] sample_out_l,
    input logic [fir_interp_pkg::sample_w-1:0] sample_out_r
);

    // done only comes with an output strobe
    assert property (@(posedge reset) disable iff (clk)
        done |-> sample_out_rdy)
        else $error("done high without sample_out_rdy");

    // Strobes are single-cycle pulses
    assert property (@(posedge reset) disable iff (clk)
        sample_out_rdy |=> !sample_out_rdy)
        else $error("sample_out_rdy high for two cycles in a row");

    // Data outputs are zero between strobes
    assert property (@(posedge reset) disable iff (clk)
        !sample_out_rdy |-> (sample_out_l == '0 && sample_out_r == '0))
        else $error("output data not zero while sample_out_rdy is low");

endmodule

/* fir_interp_8x.sv */
/*
 * Stereo 8x interpolating FIR, 192 kHz in, 1536 kHz out
 * Each input pair yields eight output strobes, one per
 * polyphase branch. Output is accumulator bits 33:16,
 * truncated. done marks the eighth output.
 */
`timescale 1ns/1ns

module fir_interp_8x (
    input  logic                                       reset,
    input  logic                                       clk,
    input  logic                                       sample_in_rdy,
    input  logic signed [fir_interp_pkg::sample_w-1:0] sample_in_l,
    input  logic signed [fir_interp_pkg::sample_w-1:0] sample_in_r,
    output logic                                       sample_out_rdy,
    output logic signed [fir_interp_pkg::sample_w-1:0] sample_out_l,
    output logic signed [fir_interp_pkg::sample_w-1:0] sample_out_r,
    output logic                                       done
);

    logic signed [fir_interp_pkg::sample_w-1:0] in_l;
    logic signed [fir_interp_pkg::sample_w-1:0] in_r;
    logic signed [fir_interp_pkg::sample_w-1:0] x_l;
    logic signed [fir_interp_pkg::sample_w-1:0] x_r;
    logic signed [fir_interp_pkg::sample_w-1:0] coef;
    logic signed [fir_interp_pkg::acc_w-1:0]    acc_l;
    logic signed [fir_interp_pkg::acc_w-1:0]    acc_r;
    logic        [fir_interp_pkg::idx_w-1:0]    tap_idx;
    logic        [fir_interp_pkg::idx_w-1:0]    phase_idx;
    logic        [fir_interp_pkg::idx_w-1:0]    rd_ptr;
    logic        [fir_interp_pkg::idx_w-1:0]    head_ptr;
    logic push, mac, clr_i, inc_i, clr_j, inc_j;
    logic load_ix, inc_ix, emit, repeat_on;
    logic repeat_busy, phase_wrap, tap_first;

    // Phase index back at 0 means all eight phases are out
    assign phase_wrap = (phase_idx == '0);

    // ----------------------------------------
    // Input sample register
    // ----------------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            in_l <= '0;
            in_r <= '0;
        end else if (sample_in_rdy) begin
            in_l <= sample_in_l;
            in_r <= sample_in_r;
        end
    end

    fir_interp_seq u_seq (
        .reset(reset), .clk(clk), .sample_in_rdy(sample_in_rdy),
        .repeat_busy(repeat_busy), .phase_wrap(phase_wrap),
        .push(push), .mac(mac), .clr_i(clr_i), .inc_i(inc_i),
        .clr_j(clr_j), .inc_j(inc_j), .load_ix(load_ix), .inc_ix(inc_ix),
        .emit(emit), .repeat_on(repeat_on)
    );

    fir_interp_index_timer u_timer (
        .reset(reset), .clk(clk), .repeat_on(repeat_on),
        .clr_i(clr_i), .inc_i(inc_i), .clr_j(clr_j), .inc_j(inc_j),
        .load_ix(load_ix), .inc_ix(inc_ix), .head_ptr(head_ptr),
        .repeat_busy(repeat_busy), .tap_idx(tap_idx), .phase_idx(phase_idx),
        .rd_ptr(rd_ptr), .tap_first(tap_first)
    );

    fir_interp_delay_line u_delay (
        .reset(reset), .clk(clk), .push(push), .wr_l(in_l), .wr_r(in_r),
        .rd_ptr(rd_ptr), .head_ptr(head_ptr), .x_l(x_l), .x_r(x_r)
    );

    fir_interp_coef_rom u_rom (
        .phase_idx(phase_idx), .tap_idx(tap_idx), .coef(coef)
    );

    fir_interp_mac_lane mac_l (
        .reset(reset), .clk(clk), .mac(mac), .tap_first(tap_first),
        .coef(coef), .x(x_l), .acc(acc_l)
    );

    fir_interp_mac_lane mac_r (
        .reset(reset), .clk(clk), .mac(mac), .tap_first(tap_first),
        .coef(coef), .x(x_r), .acc(acc_r)
    );

    // ----------------------------------------
    // Output registers, one-cycle pulses
    // ----------------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            sample_out_rdy <= 1'b0;
            sample_out_l   <= '0;
            sample_out_r   <= '0;
            done           <= 1'b0;
        end else if (emit) begin
            sample_out_rdy <= 1'b1;
            sample_out_l   <= acc_l[fir_interp_pkg::out_lsb +: fir_interp_pkg::sample_w];
            sample_out_r   <= acc_r[fir_interp_pkg::out_lsb +: fir_interp_pkg::sample_w];
            done           <= phase_wrap;
        end else begin
            sample_out_rdy <= 1'b0;
            sample_out_l   <= '0;
            sample_out_r   <= '0;
            done           <= 1'b0;
        end
    end

endmodule

/* fir_interp_mac_lane.sv */
/*
 * FIR multiply-accumulate lane
 * One channel. The first tap loads the product,
 * later taps add to it.
 */
`timescale 1ns/1ns

module fir_interp_mac_lane (
    input  logic                                       reset,
    input  logic                                       clk,
    input  logic                                       mac,
    input  logic                                       tap_first,
    input  logic signed [fir_interp_pkg::sample_w-1:0] coef,
    input  logic signed [fir_interp_pkg::sample_w-1:0] x,
    output logic signed [fir_interp_pkg::acc_w-1:0]    acc
);

    logic signed [2*fir_interp_pkg::sample_w-1:0] prod;
    logic signed [fir_interp_pkg::acc_w-1:0]      prod_ext;

    assign prod     = coef * x;
    // Signed assignment extends the sign into the upper bits
    assign prod_ext = prod;

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            acc <= '0;
        end else if (mac) begin
            acc <= tap_first ? prod_ext : acc + prod_ext;
        end
    end

endmodule

/* fir_interp_coef_rom.sv */
/*
 * FIR coefficient table
 * 56 symmetric low-pass taps, 20 kHz passband at
 * 1536 kHz, stored polyphase. Address is phase*8+tap,
 * so entry {j,i} holds c[i*8+j].
 */
`timescale 1ns/1ns

module fir_interp_coef_rom (
    input  logic        [fir_interp_pkg::idx_w-1:0]    phase_idx,
    input  logic        [fir_interp_pkg::idx_w-1:0]    tap_idx,
    output logic signed [fir_interp_pkg::sample_w-1:0] coef
);

    always_comb begin
        case ({phase_idx, tap_idx})
            // Phase 0
            6'o00: coef = 18'h3FFF4;
            6'o01: coef = 18'h0032F;
            6'o02: coef = 18'h3E5F2;
            6'o03: coef = 18'h0A8DF;
            6'o04: coef = 18'h082A2;
            6'o05: coef = 18'h3E89D;
            6'o06: coef = 18'h002C3;
            // Phase 1
            6'o10: coef = 18'h3FFF0;
            6'o11: coef = 18'h002DC;
            6'o12: coef = 18'h3E7CE;
            6'o13: coef = 18'h0CA17;
            6'o14: coef = 18'h05B56;
            6'o15: coef = 18'h3EDE7;
            6'o16: coef = 18'h00201;
            // Phase 2
            6'o20: coef = 18'h3FFFE;
            6'o21: coef = 18'h0015F;
            6'o22: coef = 18'h3EFF9;
            6'o23: coef = 18'h0E2A1;
            6'o24: coef = 18'h036A8;
            6'o25: coef = 18'h3F417;
            6'o26: coef = 18'h00138;
            // Phase 3
            6'o30: coef = 18'h00031;
            6'o31: coef = 18'h3FE65;
            6'o32: coef = 18'h3FFB9;
            6'o33: coef = 18'h0EFAA;
            6'o34: coef = 18'h01781;
            6'o35: coef = 18'h3F9DC;
            6'o36: coef = 18'h00098;
            // Phase 4
            6'o40: coef = 18'h00098;
            6'o41: coef = 18'h3F9DC;
            6'o42: coef = 18'h01781;
            6'o43: coef = 18'h0EFAA;
            6'o44: coef = 18'h3FFB9;
            6'o45: coef = 18'h3FE65;
            6'o46: coef = 18'h00031;
            // Phase 5
            6'o50: coef = 18'h00138;
            6'o51: coef = 18'h3F417;
            6'o52: coef = 18'h036A8;
            6'o53: coef = 18'h0E2A1;
            6'o54: coef = 18'h3EFF9;
            6'o55: coef = 18'h0015F;
            6'o56: coef = 18'h3FFFE;
            // Phase 6
            6'o60: coef = 18'h00201;
            6'o61: coef = 18'h3EDE7;
            6'o62: coef = 18'h05B56;
            6'o63: coef = 18'h0CA17;
            6'o64: coef = 18'h3E7CE;
            6'o65: coef = 18'h002DC;
            6'o66: coef = 18'h3FFF0;
            // Phase 7
            6'o70: coef = 18'h002C3;
            6'o71: coef = 18'h3E89D;
            6'o72: coef = 18'h082A2;
            6'o73: coef = 18'h0A8DF;
            6'o74: coef = 18'h3E5F2;
            6'o75: coef = 18'h0032F;
            6'o76: coef = 18'h3FFF4;
            default: coef = '0;
        endcase
    end

endmodule

/* fir_interp_delay_line.sv */
/*
 * FIR delay line
 * Seven-entry stereo circular sample store. A push
 * writes at the head and moves it down with wrap.
 * Reads are combinational at the given index.
 */
`timescale 1ns/1ns

module fir_interp_delay_line (
    input  logic                                       reset,
    input  logic                                       clk,
    input  logic                                       push,
    input  logic signed [fir_interp_pkg::sample_w-1:0] wr_l,
    input  logic signed [fir_interp_pkg::sample_w-1:0] wr_r,
    input  logic        [fir_interp_pkg::idx_w-1:0]    rd_ptr,
    output logic        [fir_interp_pkg::idx_w-1:0]    head_ptr,
    output logic signed [fir_interp_pkg::sample_w-1:0] x_l,
    output logic signed [fir_interp_pkg::sample_w-1:0] x_r
);

    logic signed [fir_interp_pkg::sample_w-1:0] mem_l [fir_interp_pkg::num_taps];
    logic signed [fir_interp_pkg::sample_w-1:0] mem_r [fir_interp_pkg::num_taps];

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            head_ptr <= '0;
        end else if (push) begin
            head_ptr <= (head_ptr == '0) ? fir_interp_pkg::last_tap : head_ptr - 1'b1;
        end
    end

    // Storage, cleared by the init pushes
    always_ff @(posedge reset) begin
        if (push) begin
            mem_l[head_ptr] <= wr_l;
            mem_r[head_ptr] <= wr_r;
        end
    end

    assign x_l = mem_l[rd_ptr];
    assign x_r = mem_r[rd_ptr];

endmodule

/* fir_interp_index_timer.sv */
/*
 * FIR index timer
 * Repeat counter for the seven-cycle steps, plus the
 * tap, phase and circular delay-line read indices
 */
`timescale 1ns/1ns

module fir_interp_index_timer (
    input  logic                             reset,
    input  logic                             clk,
    input  logic                             repeat_on,
    input  logic                             clr_i,
    input  logic                             inc_i,
    input  logic                             clr_j,
    input  logic                             inc_j,
    input  logic                             load_ix,
    input  logic                             inc_ix,
    input  logic [fir_interp_pkg::idx_w-1:0] head_ptr,
    output logic                             repeat_busy,
    output logic [fir_interp_pkg::idx_w-1:0] tap_idx,
    output logic [fir_interp_pkg::idx_w-1:0] phase_idx,
    output logic [fir_interp_pkg::idx_w-1:0] rd_ptr,
    output logic                             tap_first
);

    logic [fir_interp_pkg::idx_w-1:0] repeat_cnt;

    // Busy until the seventh cycle of a repeating step
    assign repeat_busy = repeat_on && (repeat_cnt != fir_interp_pkg::last_tap);
    assign tap_first   = (tap_idx == '0);

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            repeat_cnt <= '0;
        end else if (repeat_busy) begin
            repeat_cnt <= repeat_cnt + 1'b1;
        end else begin
            repeat_cnt <= '0;
        end
    end

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            tap_idx   <= '0;
            phase_idx <= '0;
            rd_ptr    <= '0;
        end else begin
            if (clr_i) begin
                tap_idx <= '0;
            end else if (inc_i) begin
                tap_idx <= tap_idx + 1'b1;
            end

            if (clr_j) begin
                phase_idx <= '0;
            end else if (inc_j) begin
                phase_idx <= (phase_idx == fir_interp_pkg::last_phase) ? '0
                                                                       : phase_idx + 1'b1;
            end

            // Walks from the newest sample towards older ones
            if (load_ix) begin
                rd_ptr <= head_ptr;
            end else if (inc_ix) begin
                rd_ptr <= (rd_ptr == fir_interp_pkg::last_tap) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

endmodule

/* fir_interp_seq.sv */
/*
 * FIR sequencer
 * Program counter with a combinational step decoder.
 * Waits for an input strobe, repeats the init and MAC
 * steps seven times and loops over the eight phases.
 */
`timescale 1ns/1ns

module fir_interp_seq (
    input  logic reset,
    input  logic clk,
    input  logic sample_in_rdy,
    input  logic repeat_busy,
    input  logic phase_wrap,
    output logic push,
    output logic mac,
    output logic clr_i,
    output logic inc_i,
    output logic clr_j,
    output logic inc_j,
    output logic load_ix,
    output logic inc_ix,
    output logic emit,
    output logic repeat_on
);

    logic [fir_interp_pkg::step_w-1:0]    pc;
    logic [fir_interp_pkg::step_w-1:0]    pc_next;
    logic [fir_interp_pkg::num_tasks-1:0] tasks;

    // ----------------------------------------
    // Step decoder
    // ----------------------------------------
    always_comb begin
        tasks = '0;
        case (pc)
            fir_interp_pkg::step_init: begin
                // Zeros from the cleared input register fill the line
                tasks[fir_interp_pkg::task_push]   = 1'b1;
                tasks[fir_interp_pkg::task_repeat] = 1'b1;
            end
            fir_interp_pkg::step_load: begin
                tasks[fir_interp_pkg::task_push]    = 1'b1;
                tasks[fir_interp_pkg::task_clr_i]   = 1'b1;
                tasks[fir_interp_pkg::task_clr_j]   = 1'b1;
                tasks[fir_interp_pkg::task_load_ix] = 1'b1;
            end
            fir_interp_pkg::step_mac: begin
                tasks[fir_interp_pkg::task_mac]    = 1'b1;
                tasks[fir_interp_pkg::task_inc_i]  = 1'b1;
                tasks[fir_interp_pkg::task_inc_ix] = 1'b1;
                tasks[fir_interp_pkg::task_repeat] = 1'b1;
            end
            fir_interp_pkg::step_next: begin
                tasks[fir_interp_pkg::task_clr_i] = 1'b1;
                tasks[fir_interp_pkg::task_inc_j] = 1'b1;
            end
            fir_interp_pkg::step_emit: begin
                tasks[fir_interp_pkg::task_emit] = 1'b1;
            end
            default: begin
                tasks = '0;
            end
        endcase
    end

    assign push      = tasks[fir_interp_pkg::task_push];
    assign mac       = tasks[fir_interp_pkg::task_mac];
    assign clr_i     = tasks[fir_interp_pkg::task_clr_i];
    assign inc_i     = tasks[fir_interp_pkg::task_inc_i];
    assign clr_j     = tasks[fir_interp_pkg::task_clr_j];
    assign inc_j     = tasks[fir_interp_pkg::task_inc_j];
    assign load_ix   = tasks[fir_interp_pkg::task_load_ix];
    assign inc_ix    = tasks[fir_interp_pkg::task_inc_ix];
    assign emit      = tasks[fir_interp_pkg::task_emit];
    assign repeat_on = tasks[fir_interp_pkg::task_repeat];

    // ----------------------------------------
    // Program counter
    // ----------------------------------------
    always_comb begin
        pc_next = pc + 1'b1;
        if (pc == fir_interp_pkg::step_wait && !sample_in_rdy) begin
            pc_next = pc;
        end else if (repeat_on && repeat_busy) begin
            pc_next = pc;
        end else if (pc == fir_interp_pkg::step_emit) begin
            // Back to idle after the eighth phase
            pc_next = phase_wrap ? fir_interp_pkg::step_wait : fir_interp_pkg::step_mac;
        end
    end

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            pc <= fir_interp_pkg::step_init;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

/* fir_interp_pkg.sv */
/*
 * Stereo 8x interpolating FIR, shared definitions
 * Data widths, tap and phase counts, the sequencer
 * step encoding and the task strobe bit positions
 */
package fir_interp_pkg;

    localparam int sample_w   = 18;
    localparam int acc_w      = 48;
    localparam int out_lsb    = 16;
    localparam int num_taps   = 7;
    localparam int num_phases = 8;
    localparam int idx_w      = 3;
    localparam int step_w     = 3;

    // Wrap points of the index registers
    localparam logic [idx_w-1:0] last_tap   = idx_w'(num_taps - 1);
    localparam logic [idx_w-1:0] last_phase = idx_w'(num_phases - 1);

    // ----------------------------------------
    // Sequencer steps
    // ----------------------------------------
    localparam logic [step_w-1:0] step_init  = 3'd0;
    localparam logic [step_w-1:0] step_wait  = 3'd1;
    localparam logic [step_w-1:0] step_load  = 3'd2;
    localparam logic [step_w-1:0] step_mac   = 3'd3;
    localparam logic [step_w-1:0] step_next  = 3'd4;
    localparam logic [step_w-1:0] step_drain = 3'd5;
    localparam logic [step_w-1:0] step_emit  = 3'd6;

    // ----------------------------------------
    // Task strobe bit positions
    // ----------------------------------------
    localparam int task_push    = 0;
    localparam int task_mac     = 1;
    localparam int task_clr_i   = 2;
    localparam int task_inc_i   = 3;
    localparam int task_clr_j   = 4;
    localparam int task_inc_j   = 5;
    localparam int task_load_ix = 6;
    localparam int task_inc_ix  = 7;
    localparam int task_emit    = 8;
    localparam int task_repeat  = 9;
    localparam int num_tasks    = 10;

endpackage
